// File: src/csr_index_pkg.sv
/*
 * Shared widths and types for the CSR index generator
 * Index, address and shift types, sequencer state encoding
 */

package csr_index_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    parameter int INDEX_WIDTH   = 32;
    parameter int ADDRESS_WIDTH = 32;
    parameter int SHIFT_WIDTH   = 5;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef logic [INDEX_WIDTH-1:0]   index_t;
    typedef logic [ADDRESS_WIDTH-1:0] address_t;
    typedef logic [SHIFT_WIDTH-1:0]   shift_t;

    // Run state machine of the index sequencer
    typedef enum logic [3:0] {
        RESET       = 4'd0,
        IDLE        = 4'd1,
        SETUP       = 4'd2,
        START       = 4'd3,
        BUSY        = 4'd4,
        BUSY_TRANS  = 4'd5,
        PAUSE_TRANS = 4'd6,
        PAUSE       = 4'd7,
        DONE        = 4'd8
    } sequencer_state_t;

endpackage : csr_index_pkg

// File: src/csr_index_sequencer.sv
/*
 * Index sequencer of the CSR index generator
 * Configuration capture, run state machine and stride counter
 */

`timescale 1ns/1ns

module csr_index_sequencer
    import csr_index_pkg::*;
(
    input  logic   ap_clk,
    input  logic   areset_generator,
    input  logic   config_valid,
    input  index_t config_index_start,
    input  index_t config_index_end,
    input  index_t config_stride,
    input  logic   prog_full,
    output logic   config_accept,
    output logic   idle,
    output logic   done,
    output logic   gen_valid,
    output index_t gen_index
);

    // ------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------
    sequencer_state_t state;
    sequencer_state_t next_state;

    index_t start_reg;
    index_t end_reg;
    index_t stride_reg;

    // One extra bit so a stride past the top of the range cannot wrap
    logic [INDEX_WIDTH:0] count;
    logic                 end_hit;

    // ------------------------------------------------------------------
    // Configuration capture
    // ------------------------------------------------------------------
    // A strobe counts only while the sequencer sits in IDLE
    assign config_accept = config_valid && (state == IDLE);

    always_ff @(posedge ap_clk) begin
        if (config_accept) begin
            start_reg  <= config_index_start;
            end_reg    <= config_index_end;
            stride_reg <= config_stride;
        end
    end

    // ------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (config_accept) begin
                    next_state = SETUP;
                end
            end
            SETUP: begin
                next_state = START;
            end
            START: begin
                next_state = BUSY;
            end
            BUSY: begin
                if (end_hit) begin
                    next_state = DONE;
                end else if (prog_full) begin
                    next_state = PAUSE_TRANS;
                end
            end
            PAUSE_TRANS: begin
                next_state = PAUSE;
            end
            PAUSE: begin
                // Wait for the FIFO to drain below threshold
                if (!prog_full) begin
                    next_state = BUSY_TRANS;
                end
            end
            BUSY_TRANS: begin
                next_state = BUSY;
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Stride counter
    // ------------------------------------------------------------------
    assign end_hit = count >= {1'b0, end_reg};

    always_ff @(posedge ap_clk) begin
        if (state == SETUP) begin
            count <= {1'b0, start_reg};
        end else if (gen_valid) begin
            count <= count + {1'b0, stride_reg};
        end
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    // One index per BUSY cycle until the end is reached
    assign gen_valid = (state == BUSY) && !end_hit;
    assign gen_index = count[INDEX_WIDTH-1:0];

    assign idle = (state == IDLE);
    assign done = (state == DONE);

    // ------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------
    // At most one index goes out after prog_full is seen
    stop_on_prog_full : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        gen_valid && prog_full |=> !gen_valid
    ) else $error("gen_valid continued while prog_full was high");

endmodule : csr_index_sequencer

// File: src/csr_address_map.sv
/*
 * Request address stage
 * Base and shift capture, one registered index to address step
 */

`timescale 1ns/1ns

module csr_address_map
    import csr_index_pkg::*;
(
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     config_accept,
    input  address_t config_base_address,
    input  shift_t   config_shift_amount,
    input  logic     config_shift_left,
    input  logic     gen_valid,
    input  index_t   gen_index,
    output logic     push,
    output index_t   push_index,
    output address_t push_address
);

    address_t base_address;
    shift_t   shift_amount;
    logic     shift_left;
    address_t index_wide;
    address_t offset;

    // Mapping parameters held for the whole run
    always_ff @(posedge ap_clk) begin
        if (config_accept) begin
            base_address <= config_base_address;
            shift_amount <= config_shift_amount;
            shift_left   <= config_shift_left;
        end
    end

    always_comb begin
        index_wide = address_t'(gen_index);
        if (shift_left) begin
            offset = index_wide << shift_amount;
        end else begin
            offset = index_wide >> shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push <= 1'b0;
        end else begin
            push <= gen_valid;
        end
    end

    // Sum wraps at the address width
    always_ff @(posedge ap_clk) begin
        push_index   <= gen_index;
        push_address <= base_address + offset;
    end

endmodule : csr_address_map

// File: src/request_fifo.sv
/*
 * Synchronous request FIFO with programmable-full flag
 * Holds index and address pairs, pops on valid and ready
 */

`timescale 1ns/1ns

module request_fifo
    import csr_index_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     push,
    input  index_t   push_index,
    input  address_t push_address,
    input  logic     pop_ready,
    output logic     request_valid,
    output index_t   request_index,
    output address_t request_address,
    output logic     prog_full
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    // ------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------
    index_t   index_mem   [FIFO_DEPTH];
    address_t address_mem [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full  = count == (PTR_WIDTH+1)'(FIFO_DEPTH);
    assign wr_en = push && !full;
    assign rd_en = request_valid && pop_ready;

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            index_mem[wr_ptr]   <= push_index;
            address_mem[wr_ptr] <= push_address;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                if (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                if (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else if (wr_en && !rd_en) begin
            count <= count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
        end
    end

    // Head entry shown directly from storage
    assign request_valid   = count != '0;
    assign request_index   = index_mem[rd_ptr];
    assign request_address = address_mem[rd_ptr];
    assign prog_full       = count >= (PTR_WIDTH+1)'(PROG_THRESH);

    // Pause logic upstream must keep headroom above the threshold
    no_push_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        push |-> !full
    ) else $error("request FIFO overflow");

endmodule : request_fifo

// File: src/csr_index_generator.sv
/*
 * CSR index generator top level
 * Sequencer, address stage and request FIFO
 */

`timescale 1ns/1ns

module csr_index_generator
    import csr_index_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     config_valid,
    input  index_t   config_index_start,
    input  index_t   config_index_end,
    input  index_t   config_stride,
    input  address_t config_base_address,
    input  shift_t   config_shift_amount,
    input  logic     config_shift_left,
    input  logic     request_ready,
    output logic     idle,
    output logic     done,
    output logic     request_valid,
    output index_t   request_index,
    output address_t request_address
);

    logic     config_accept;
    logic     gen_valid;
    index_t   gen_index;
    logic     push;
    index_t   push_index;
    address_t push_address;
    logic     prog_full;

    csr_index_sequencer i_csr_index_sequencer (
        .ap_clk             (ap_clk),
        .areset_generator   (areset_generator),
        .config_valid       (config_valid),
        .config_index_start (config_index_start),
        .config_index_end   (config_index_end),
        .config_stride      (config_stride),
        .prog_full          (prog_full),
        .config_accept      (config_accept),
        .idle               (idle),
        .done               (done),
        .gen_valid          (gen_valid),
        .gen_index          (gen_index)
    );

    csr_address_map i_csr_address_map (
        .ap_clk              (ap_clk),
        .areset_generator    (areset_generator),
        .config_accept       (config_accept),
        .config_base_address (config_base_address),
        .config_shift_amount (config_shift_amount),
        .config_shift_left   (config_shift_left),
        .gen_valid           (gen_valid),
        .gen_index           (gen_index),
        .push                (push),
        .push_index          (push_index),
        .push_address        (push_address)
    );

    // Output buffer, prog_full stalls the sequencer
    request_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) i_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_index       (push_index),
        .push_address     (push_address),
        .pop_ready        (request_ready),
        .request_valid    (request_valid),
        .request_index    (request_index),
        .request_address  (request_address),
        .prog_full        (prog_full)
    );

endmodule : csr_index_generator

// File: tests/tb_csr_index_generator.sv
/*
 * Testbench for the CSR index generator
 * Clock, reset, stimulus replay from file, reference model and checks
 */

`timescale 1ns/1ns

module tb_csr_index_generator
    import csr_index_pkg::*;
();

    localparam int FIELDS    = 9;
    localparam int MAX_TESTS = 32;

    logic     ap_clk;
    logic     areset_generator;
    logic     config_valid;
    index_t   config_index_start;
    index_t   config_index_end;
    index_t   config_stride;
    address_t config_base_address;
    shift_t   config_shift_amount;
    logic     config_shift_left;
    logic     request_ready;
    logic     idle;
    logic     done;
    logic     request_valid;
    index_t   request_index;
    address_t request_address;

    logic [31:0] stim_mem [0:MAX_TESTS*FIELDS-1];
    logic [31:0] lfsr_state = 32'h51b8;
    int          error_count = 0;
    int          num_tests = 0;
    int          timeout_limit = 0;
    int          cycle_count = 0;

    csr_index_generator i_csr_index_generator (
        .ap_clk              (ap_clk),
        .areset_generator    (areset_generator),
        .config_valid        (config_valid),
        .config_index_start  (config_index_start),
        .config_index_end    (config_index_end),
        .config_stride       (config_stride),
        .config_base_address (config_base_address),
        .config_shift_amount (config_shift_amount),
        .config_shift_left   (config_shift_left),
        .request_ready       (request_ready),
        .idle                (idle),
        .done                (done),
        .request_valid       (request_valid),
        .request_index       (request_index),
        .request_address     (request_address)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    function automatic int expected_count(input index_t first, input index_t last,
                                          input index_t step);
        longint idx;
        int     n;
        idx = longint'(first);
        n   = 0;
        while (idx < longint'(last) && n < 32'hffff) begin
            n++;
            idx = idx + longint'(step);
        end
        return n;
    endfunction

    function automatic address_t ref_address(input address_t base, input index_t idx,
                                             input shift_t amount, input logic left);
        if (left) begin
            return base + (address_t'(idx) << amount);
        end
        return base + (address_t'(idx) >> amount);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // One run from the stimulus table
    // ------------------------------------------------------------------
    task automatic run_test(input int t);
        index_t   start_idx;
        index_t   end_idx;
        index_t   stride;
        address_t base;
        shift_t   amount;
        logic     left;
        logic     ready_random;
        logic     busy_strobe;
        int       file_count;
        int       pops;
        int       done_pulses;
        int       errors_before;
        bit       strobed;
        bit       finished;
        index_t   exp_idx;
        start_idx    = stim_mem[t*FIELDS];
        end_idx      = stim_mem[t*FIELDS+1];
        stride       = stim_mem[t*FIELDS+2];
        base         = stim_mem[t*FIELDS+3];
        amount       = shift_t'(stim_mem[t*FIELDS+4]);
        left         = stim_mem[t*FIELDS+5][0];
        ready_random = stim_mem[t*FIELDS+6][0];
        busy_strobe  = stim_mem[t*FIELDS+7][0];
        file_count   = stim_mem[t*FIELDS+8];
        errors_before = error_count;
        pops = 0;
        done_pulses = 0;
        strobed = 0;
        finished = 0;
        check_value("stimulus count", file_count, expected_count(start_idx, end_idx, stride));

        while (!idle) @(negedge ap_clk);
        config_valid        = 1'b1;
        config_index_start  = start_idx;
        config_index_end    = end_idx;
        config_stride       = stride;
        config_base_address = base;
        config_shift_amount = amount;
        config_shift_left   = left;

        while (!finished) begin
            @(negedge ap_clk);
            config_valid = 1'b0;
            if (ready_random) begin
                lfsr_state    = lfsr_step(lfsr_state);
                request_ready = lfsr_state[0];
            end else begin
                request_ready = 1'b1;
            end
            if (done) begin
                done_pulses++;
            end
            // Head entry pops at the coming rising edge
            if (request_valid && request_ready) begin
                exp_idx = index_t'(longint'(start_idx) + longint'(pops) * longint'(stride));
                check_value("request_index", request_index, exp_idx);
                check_value("request_address", request_address,
                            ref_address(base, exp_idx, amount, left));
                pops++;
            end
            // Junk configuration while the run is active
            if (busy_strobe && !strobed && pops >= 2 && !idle) begin
                config_valid        = 1'b1;
                config_index_start  = '0;
                config_index_end    = 32'h0000ffff;
                config_stride       = 32'd1;
                config_base_address = 32'hdead0000;
                config_shift_amount = 5'd7;
                config_shift_left   = ~left;
                strobed = 1;
            end
            if (done_pulses > 0 && !request_valid) begin
                finished = 1;
            end
        end

        // Quiet tail, nothing more may appear
        repeat (4) begin
            @(negedge ap_clk);
            request_ready = 1'b1;
            if (request_valid) begin
                pops++;
            end
            if (done) begin
                done_pulses++;
            end
        end

        if (busy_strobe && !strobed) begin
            $display("Test %0d could not issue the strobe while the run was active", t);
            error_count++;
        end
        check_value("request count", pops, file_count);
        check_value("done pulses", done_pulses, 1);
        check_value("idle", idle, 1'b1);
        $display("Test %0d: %0d requests, %0d done pulses, %s", t, pops, done_pulses,
                 (error_count == errors_before) ? "ok" : "errors");
    endtask

    // ------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------
    initial begin : watchdog
        wait (timeout_limit != 0);
        @(negedge areset_generator);
        while (cycle_count < timeout_limit) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin : main_sequence
        int wait_cycles;
        areset_generator    = 1'b1;
        config_valid        = 1'b0;
        config_index_start  = '0;
        config_index_end    = '0;
        config_stride       = '0;
        config_base_address = '0;
        config_shift_amount = '0;
        config_shift_left   = 1'b0;
        request_ready       = 1'b0;

        $readmemh("tests/csr_index_stimulus.txt", stim_mem);
        while (num_tests < MAX_TESTS && !$isunknown(stim_mem[num_tests*FIELDS])) begin
            timeout_limit += 4 * stim_mem[num_tests*FIELDS+8] + 50;
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("No tests were found in the stimulus file");
            error_count++;
        end

        repeat (16) @(negedge ap_clk);
        areset_generator = 1'b0;
        check_value("request_valid", request_valid, 1'b0);
        check_value("done", done, 1'b0);
        check_value("idle", idle, 1'b0);
        wait_cycles = 0;
        while (!idle && wait_cycles < 2) begin
            @(negedge ap_clk);
            wait_cycles++;
        end
        check_value("idle", idle, 1'b1);
        $display("Reset: idle after %0d cycles", wait_cycles);

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("Tests run: %0d, failed checks: %0d", num_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_csr_index_generator

// File: all.f
src/csr_index_pkg.sv
src/csr_index_sequencer.sv
src/csr_address_map.sv
src/request_fifo.sv
src/csr_index_generator.sv
tests/tb_csr_index_generator.sv

// File: tests/csr_index_stimulus.txt
// Columns: start end stride base shift_amount shift_left ready_mode busy_strobe count
// ready_mode 0 holds request_ready high, 1 draws it from the LFSR
// Ascending run, left shift, ready always high
00000000 00000010 00000001 00001000 02 1 0 0 00000010
// Right shift, stride 5, nonzero base
00000003 00000040 00000005 80000000 01 0 0 0 0000000d
// Long run under random ready, FIFO fills and generation pauses
00000100 00000160 00000001 20000000 03 1 1 0 00000060
// Empty range, start equal to end
00000050 00000050 00000002 00004000 01 1 0 0 00000000
// Empty range, start above end
00000090 00000010 00000001 00000000 00 0 0 0 00000000
// Strobe while busy must be ignored
00000010 00000050 00000002 0000fff0 04 1 0 1 00000020
// Stride steps past the top of the index range
fffffff0 ffffffff 00000008 00000000 00 0 0 0 00000002
// Random ready, right shift, busy strobe
00000000 00000090 00000003 00010000 05 0 1 1 00000030
